//--- sim.f
+incdir+include
verilog/agg_pkg.sv
verilog/input_enqueue.sv
verilog/striped_memory.sv
verilog/packet_dequeue.sv
verilog/packet_aggregate.sv
sim/tb_packet_aggregate.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= tb_packet_aggregate
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := FAIL: see errors above
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the result"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_packet_aggregate.sv
// Testbench with directed and random packet traffic, expected word queues and output checks
`timescale 1ns/1ps
`include "agg_defines.svh"

module tb_packet_aggregate
    import agg_pkg::*;
();

    localparam int pkts_per_input = 12;
    localparam int ready_timeout  = 4000;
    localparam int drain_timeout  = 20000;

    logic                       clk_in = 1'b0;
    logic                       rst = 1'b1;
    in_beat_t                   in_beat [`agg_num_inputs];
    logic [`agg_num_inputs-1:0] in_ready;
    out_beat_t                  out_beat;
    logic                       out_ready = 1'b1;
    logic                       random_ready = 1'b0;

    // Words and sizes in send order, one queue per input
    in_word_t                   exp_words [`agg_num_inputs][$];
    int                         exp_sizes [`agg_num_inputs][$];

    int                         errors = 0;
    int                         timeouts = 0;
    int                         pkts_received = 0;
    bit                         timed_out = 1'b0;
    logic                       in_pkt = 1'b0;
    ctxt_t                      pkt_ctxt;
    int                         pkt_size;
    int                         pkt_beat;
    int                         pkt_beats;
    logic                       stall_held = 1'b0;
    out_beat_t                  held_beat;

    packet_aggregate dut0 (
        .clk_in    (clk_in),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    always #10 clk_in = ~clk_in;

    // Output back-pressure, random only in the traffic phase
    always @(posedge clk_in) begin
        #2;
        if (random_ready) begin
            out_ready = ($urandom % 4) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Output checks
    // ------------------------------------------------------------------------
    task automatic check_beat();
        int       exp_n;
        int       lane;
        logic     exp_last;
        in_word_t exp_w;
        in_word_t got_w;
        if (!in_pkt) begin
            if (exp_sizes[out_beat.ctxt].size() == 0) begin
                $display("Unexpected packet on ctxt %0d, nothing was sent there", out_beat.ctxt);
                errors++;
                return;
            end
            pkt_ctxt  = out_beat.ctxt;
            pkt_size  = exp_sizes[pkt_ctxt].pop_front();
            pkt_beats = (pkt_size + `agg_num_cols - 1) / `agg_num_cols;
            pkt_beat  = 0;
            in_pkt    = 1'b1;
        end else if (out_beat.ctxt !== pkt_ctxt) begin
            // Another input may only start at a packet boundary
            $display("[FAIL] out_beat.ctxt inside packet: got %h expected %h",
                     out_beat.ctxt, pkt_ctxt);
            errors++;
        end
        exp_last = (pkt_beat == pkt_beats - 1);
        exp_n    = exp_last ? pkt_size - `agg_num_cols * (pkt_beats - 1) : `agg_num_cols;
        if (out_beat.last !== exp_last) begin
            $display("[FAIL] out_beat.last ctxt %0d beat %0d: got %h expected %h",
                     pkt_ctxt, pkt_beat, out_beat.last, exp_last);
            errors++;
        end
        if (out_beat.words !== words_t'(exp_n)) begin
            $display("[FAIL] out_beat.words ctxt %0d beat %0d: got %h expected %h",
                     pkt_ctxt, pkt_beat, out_beat.words, words_t'(exp_n));
            errors++;
        end
        for (lane = 0; lane < exp_n; lane++) begin
            if (exp_words[pkt_ctxt].size() == 0) begin
                $display("Output of ctxt %0d holds more words than were sent", pkt_ctxt);
                errors++;
            end else begin
                exp_w = exp_words[pkt_ctxt].pop_front();
                got_w = out_beat.data[lane*`agg_in_width +: `agg_in_width];
                if (got_w !== exp_w) begin
                    $display("[FAIL] out_beat.data ctxt %0d beat %0d lane %0d: got %h expected %h",
                             pkt_ctxt, pkt_beat, lane, got_w, exp_w);
                    errors++;
                end
            end
        end
        pkt_beat++;
        if (exp_last) begin
            in_pkt = 1'b0;
            pkts_received++;
        end
    endtask

    // Sampled mid-cycle, where every output is settled
    always @(negedge clk_in) begin
        if (rst) begin
            stall_held = 1'b0;
        end else begin
            if (stall_held && out_beat !== held_beat) begin
                $display("[FAIL] out_beat under back-pressure: got %h expected %h",
                         out_beat, held_beat);
                errors++;
            end
            if (out_beat.valid && !out_ready) begin
                held_beat  = out_beat;
                stall_held = 1'b1;
            end else begin
                stall_held = 1'b0;
            end
            if (out_beat.valid && out_ready) begin
                check_beat();
            end
        end
    end

    task automatic check_idle(input string when_txt);
        if (out_beat.valid !== 1'b0) begin
            $display("[FAIL] out_beat.valid %s: got %h expected %h", when_txt, out_beat.valid, 1'b0);
            errors++;
        end
        if (in_ready !== '1) begin
            $display("[FAIL] in_ready %s: got %h expected %h", when_txt, in_ready, 4'hf);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic send_packet(input int idx, input int size, input bit gaps);
        int gap;
        int waited;
        int k;
        bit accepted;
        exp_sizes[idx].push_back(size);
        for (k = 0; k < size && !timed_out; k++) begin
            gap = gaps ? $urandom % 3 : 0;
            repeat (gap) begin
                @(posedge clk_in);
                #2;
            end
            in_beat[idx].valid = 1'b1;
            in_beat[idx].data  = in_word_t'($urandom);
            in_beat[idx].last  = (k == size - 1);
            accepted = 1'b0;
            waited   = 0;
            while (!accepted && waited < ready_timeout) begin
                @(negedge clk_in);
                if (in_ready[idx]) begin
                    accepted = 1'b1;
                    exp_words[idx].push_back(in_beat[idx].data);
                end else begin
                    waited++;
                end
                @(posedge clk_in);
                #2;
            end
            in_beat[idx] = '0;
            if (!accepted) begin
                $display("Timeout: input %0d held word %0d for %0d cycles without in_ready",
                         idx, k, ready_timeout);
                timeouts++;
                timed_out = 1'b1;
            end
        end
        // Page stays closed while the read side owns it
        if (!timed_out) begin
            @(negedge clk_in);
            if (in_ready[idx] !== 1'b0) begin
                $display("[FAIL] in_ready[%0d] after last word: got %h expected %h",
                         idx, in_ready[idx], 1'b0);
                errors++;
            end
            @(posedge clk_in);
            #2;
        end
    endtask

    task automatic run_input(input int idx);
        int p;
        for (p = 0; p < pkts_per_input && !timed_out; p++) begin
            send_packet(idx, 1 + ($urandom % `agg_max_words), 1'b1);
        end
    endtask

    function automatic bit all_drained();
        bit drained;
        drained = !in_pkt;
        for (int i = 0; i < `agg_num_inputs; i++) begin
            if (exp_words[i].size() != 0 || exp_sizes[i].size() != 0) begin
                drained = 1'b0;
            end
        end
        return drained;
    endfunction

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (!timed_out && !all_drained() && waited < limit) begin
            @(posedge clk_in);
            #2;
            waited++;
        end
        if (!timed_out && !all_drained()) begin
            $display("Timeout: expected packets still missing after %0d cycles", limit);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int base;
        int directed_size [`agg_num_inputs];
        void'($urandom(11162));
        directed_size = '{5, 8, 1, 32};
        for (int i = 0; i < `agg_num_inputs; i++) begin
            in_beat[i] = '0;
        end

        @(posedge clk_in);
        @(negedge clk_in);
        check_idle("during reset");
        @(posedge clk_in);
        #2;
        rst = 1'b0;
        @(negedge clk_in);
        check_idle("at reset release");
        @(negedge clk_in);
        check_idle("after reset");
        @(posedge clk_in);
        #2;

        // One packet per input in turn, no back-pressure
        for (int i = 0; i < `agg_num_inputs; i++) begin
            send_packet(i, directed_size[i], 1'b0);
            wait_drain(drain_timeout);
        end

        // All inputs at once with gaps and back-pressure
        base = pkts_received;
        random_ready = 1'b1;
        fork
            run_input(0);
            run_input(1);
            run_input(2);
            run_input(3);
        join
        wait_drain(drain_timeout);
        random_ready = 1'b0;
        if (pkts_received - base != `agg_num_inputs * pkts_per_input) begin
            $display("Only %0d of %0d random packets arrived", pkts_received - base,
                     `agg_num_inputs * pkts_per_input);
            errors++;
        end

        $display("Errors: %0d, timeouts: %0d, packets received: %0d",
                 errors, timeouts, pkts_received);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_packet_aggregate

//--- verilog/packet_aggregate.sv
// Top level joining the input stages, striped memory and dequeue
`timescale 1ns/1ps
`include "agg_defines.svh"

module packet_aggregate
    import agg_pkg::*;
(
    input  logic                       clk_in,
    input  logic                       rst,
    input  in_beat_t                   in_beat [`agg_num_inputs],
    output logic [`agg_num_inputs-1:0] in_ready,
    output out_beat_t                  out_beat,
    input  logic                       out_ready
);

    col_t                       slot;
    col_wr_t                    col_wr [`agg_num_inputs];
    desc_t                      desc [`agg_num_inputs];
    logic [`agg_num_inputs-1:0] page_release;
    logic                       rd_req;
    mem_addr_t                  rd_addr;
    out_word_t                  rd_data;

    // ------------------------------------------------------------------------
    // Input stages, one page each
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < `agg_num_inputs; i++) begin : g_in
        input_enqueue #(
            .input_index  (i)
        ) u_enq (
            .clk_in       (clk_in),
            .rst          (rst),
            .in_beat      (in_beat[i]),
            .in_ready     (in_ready[i]),
            .slot         (slot),
            .col_wr       (col_wr[i]),
            .desc         (desc[i]),
            .page_release (page_release[i])
        );
    end

    striped_memory u_mem (
        .clk_in  (clk_in),
        .rst     (rst),
        .slot    (slot),
        .col_wr  (col_wr),
        .rd_req  (rd_req),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Wide output side
    packet_dequeue u_deq (
        .clk_in       (clk_in),
        .rst          (rst),
        .desc         (desc),
        .page_release (page_release),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .out_beat     (out_beat),
        .out_ready    (out_ready)
    );

endmodule : packet_aggregate

//--- verilog/packet_dequeue.sv
// Read side with pending pages, round-robin choice, row reads and output buffer
`timescale 1ns/1ps
`include "agg_defines.svh"

module packet_dequeue
    import agg_pkg::*;
(
    input  logic                       clk_in,
    input  logic                       rst,
    input  desc_t                      desc [`agg_num_inputs],
    output logic [`agg_num_inputs-1:0] page_release,
    output logic                       rd_req,
    output mem_addr_t                  rd_addr,
    input  out_word_t                  rd_data,
    output out_beat_t                  out_beat,
    input  logic                       out_ready
);

    deq_state_t                  state;
    logic [`agg_num_inputs-1:0]  pending;
    size_t                       page_size [`agg_num_inputs];
    ctxt_t                       last_ctxt;
    ctxt_t                       next_ctxt;
    logic                        next_found;
    ctxt_t                       cur_ctxt;
    size_t                       cur_size;
    row_t                        row;
    row_t                        last_row;
    logic                        row_last;
    size_t                       rem_words;
    words_t                      row_words;

    // Tag of the row read in flight
    logic                        fl_valid;
    logic                        fl_last;
    ctxt_t                       fl_ctxt;
    words_t                      fl_words;

    out_beat_t                   obuf [2];
    logic                        obuf_wr_ptr;
    logic                        obuf_rd_ptr;
    logic [1:0]                  obuf_count;
    logic                        pop;

    // ------------------------------------------------------------------------
    // Round-robin choice
    // ------------------------------------------------------------------------
    // Search starts just after the page served last
    always_comb begin
        next_found = 1'b0;
        next_ctxt  = last_ctxt;
        for (int k = 1; k <= `agg_num_inputs; k++) begin
            if (!next_found && pending[last_ctxt + ctxt_t'(k)]) begin
                next_found = 1'b1;
                next_ctxt  = last_ctxt + ctxt_t'(k);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Row reads
    // ------------------------------------------------------------------------
    assign last_row  = row_t'((cur_size - size_t'(1)) / size_t'(`agg_num_cols));
    assign row_last  = (row == last_row);
    assign rem_words = cur_size - size_t'(row) * size_t'(`agg_num_cols);
    assign row_words = row_last ? words_t'(rem_words) : words_t'(`agg_num_cols);

    // At most two rows buffered or in flight
    assign rd_req  = (state == deq_read) && ((2'(obuf_count) + 2'(fl_valid)) < 2'd2);
    assign rd_addr = {cur_ctxt, row};

    always_comb begin
        page_release = '0;
        if (rd_req && row_last) begin
            page_release[cur_ctxt] = 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state     <= deq_idle;
            pending   <= '0;
            last_ctxt <= ctxt_t'(`agg_num_inputs - 1);
            cur_ctxt  <= '0;
            row       <= '0;
            fl_valid  <= 1'b0;
        end else begin
            for (int i = 0; i < `agg_num_inputs; i++) begin
                if (desc[i].valid) begin
                    pending[i] <= 1'b1;
                end
            end

            case (state)
                deq_idle: begin
                    if (next_found) begin
                        state              <= deq_read;
                        cur_ctxt           <= next_ctxt;
                        last_ctxt          <= next_ctxt;
                        row                <= '0;
                        pending[next_ctxt] <= 1'b0;
                    end
                end
                deq_read: begin
                    if (rd_req) begin
                        if (row_last) begin
                            state <= deq_idle;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end
                end
                default: state <= deq_idle;
            endcase

            fl_valid <= rd_req;
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < `agg_num_inputs; i++) begin
            if (desc[i].valid) begin
                page_size[i] <= desc[i].size;
            end
        end
        if (state == deq_idle && next_found) begin
            cur_size <= page_size[next_ctxt];
        end
        if (rd_req) begin
            fl_last  <= row_last;
            fl_ctxt  <= cur_ctxt;
            fl_words <= row_words;
        end
    end

    // ------------------------------------------------------------------------
    // Output buffer
    // ------------------------------------------------------------------------
    always_comb begin
        out_beat       = obuf[obuf_rd_ptr];
        out_beat.valid = (obuf_count != 2'd0);
    end

    assign pop = out_beat.valid && out_ready;

    // Returned row joins its tag one cycle after the read
    always_ff @(posedge clk_in) begin
        if (fl_valid) begin
            obuf[obuf_wr_ptr] <= '{valid: 1'b1, data: rd_data, last: fl_last,
                                   ctxt: fl_ctxt, words: fl_words};
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            obuf_wr_ptr <= 1'b0;
            obuf_rd_ptr <= 1'b0;
            obuf_count  <= '0;
        end else begin
            if (fl_valid) begin
                obuf_wr_ptr <= !obuf_wr_ptr;
            end
            if (pop) begin
                obuf_rd_ptr <= !obuf_rd_ptr;
            end
            case ({fl_valid, pop})
                2'b10:   obuf_count <= obuf_count + 1'b1;
                2'b01:   obuf_count <= obuf_count - 1'b1;
                default: obuf_count <= obuf_count;
            endcase
        end
    end

    // Held beat stays put under back-pressure
    assert property (@(posedge clk_in) disable iff (rst)
        (out_beat.valid && !out_ready) |=> $stable(out_beat))
        else $error("out_beat changed while stalled");

endmodule : packet_dequeue

//--- verilog/striped_memory.sv
// Slot rotator, write crossbar, column storage and shared row read port
`timescale 1ns/1ps
`include "agg_defines.svh"

module striped_memory
    import agg_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst,
    output col_t      slot,
    input  col_wr_t   col_wr [`agg_num_inputs],
    input  logic      rd_req,
    input  mem_addr_t rd_addr,
    output out_word_t rd_data
);

    localparam int mem_depth = `agg_num_inputs * `agg_page_rows;

    // ------------------------------------------------------------------------
    // Rotator
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_in) begin
        if (rst) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Columns
    // ------------------------------------------------------------------------
    for (genvar c = 0; c < `agg_num_cols; c++) begin : g_col
        in_word_t  col_mem [mem_depth];
        in_word_t  col_q;
        ctxt_t     owner;
        col_wr_t   wr;
        mem_addr_t wr_addr;

        // Input i owns column slot + i, so column c belongs to c - slot
        assign owner   = ctxt_t'(col_t'(c) - slot);
        assign wr      = col_wr[owner];
        assign wr_addr = {owner, wr.row};

        always_ff @(posedge clk_in) begin
            if (wr.req) begin
                col_mem[wr_addr] <= wr.data;
            end
        end

        // Registered read, all columns share one row address
        always_ff @(posedge clk_in) begin
            if (rd_req) begin
                col_q <= col_mem[rd_addr];
            end
        end

        assign rd_data[c*`agg_in_width +: `agg_in_width] = col_q;

        // Owner only writes a page the read side has not taken yet
        assert property (@(posedge clk_in) disable iff (rst)
            (rd_req && wr.req) |-> (rd_addr != wr_addr))
            else $error("column %0d write collides with row read at %0h", c, rd_addr);
    end

endmodule : striped_memory

//--- verilog/input_enqueue.sv
// Input stage with packet acceptance, write queue, column matching and page ownership
`timescale 1ns/1ps
`include "agg_defines.svh"

module input_enqueue
    import agg_pkg::*;
#(
    parameter int input_index = 0
) (
    input  logic     clk_in,
    input  logic     rst,
    input  in_beat_t in_beat,
    output logic     in_ready,
    input  col_t     slot,
    output col_wr_t  col_wr,
    output desc_t    desc,
    input  logic     page_release
);

    localparam int ptr_w = $clog2(`agg_wq_depth);

    // Queue entry, the word number is split into row and column
    typedef struct packed {
        in_word_t data;
        row_t     row;
        col_t     col;
        logic     last;
    } wq_entry_t;

    wq_entry_t        wq_mem [`agg_wq_depth];
    wq_entry_t        wq_in;
    wq_entry_t        wq_head;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   wq_count;
    logic             wq_full;
    logic             wq_empty;
    logic             push;
    logic             pop;
    size_t            word_cnt;
    logic             page_busy;
    col_t             own_col;

    // ------------------------------------------------------------------------
    // Acceptance
    // ------------------------------------------------------------------------
    assign wq_full  = (wq_count == (ptr_w+1)'(`agg_wq_depth));
    assign wq_empty = (wq_count == '0);

    // Page is closed from the last word until the read side frees it
    assign in_ready = !page_busy && !wq_full;
    assign push     = in_beat.valid && in_ready;

    always_comb begin
        wq_in.data = in_beat.data;
        {wq_in.row, wq_in.col} = word_cnt[$bits(row_t)+$bits(col_t)-1:0];
        wq_in.last = in_beat.last;
    end

    // ------------------------------------------------------------------------
    // Column matching
    // ------------------------------------------------------------------------
    // Rotating slot, each input sees a different column per cycle
    assign own_col = slot + col_t'(input_index);
    assign wq_head = wq_mem[rd_ptr];
    assign pop     = !wq_empty && (wq_head.col == own_col);

    always_comb begin
        col_wr.req  = pop;
        col_wr.row  = wq_head.row;
        col_wr.data = wq_head.data;
    end

    // Hand the page over as its final word is written
    always_comb begin
        desc.valid = pop && wq_head.last;
        desc.size  = size_t'({wq_head.row, wq_head.col}) + size_t'(1);
    end

    // ------------------------------------------------------------------------
    // Queue storage and control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_in) begin
        if (push) begin
            wq_mem[wr_ptr] <= wq_in;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            wq_count  <= '0;
            word_cnt  <= '0;
            page_busy <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   wq_count <= wq_count + 1'b1;
                2'b01:   wq_count <= wq_count - 1'b1;
                default: wq_count <= wq_count;
            endcase

            // Word numbering restarts with each packet
            if (push) begin
                word_cnt <= in_beat.last ? '0 : word_cnt + 1'b1;
            end

            if (push && in_beat.last) begin
                page_busy <= 1'b1;
            end else if (page_release) begin
                page_busy <= 1'b0;
            end
        end
    end

    // A packet never outgrows its page
    assert property (@(posedge clk_in) disable iff (rst)
        push |-> word_cnt < size_t'(`agg_max_words))
        else $error("input %0d accepted more than %0d words", input_index, `agg_max_words);

endmodule : input_enqueue

//--- verilog/agg_pkg.sv
// Vector typedefs, beat and descriptor structs and read FSM states
`include "agg_defines.svh"

package agg_pkg;

    typedef logic [`agg_in_width-1:0]               in_word_t;
    // Column 0 occupies the low bits
    typedef logic [`agg_out_width-1:0]              out_word_t;
    typedef logic [$clog2(`agg_num_cols)-1:0]       col_t;
    typedef logic [$clog2(`agg_num_inputs)-1:0]     ctxt_t;
    typedef logic [$clog2(`agg_page_rows)-1:0]      row_t;
    // Page index in the upper bits, row in the lower bits
    typedef logic [$bits(ctxt_t)+$bits(row_t)-1:0]  mem_addr_t;
    typedef logic [$clog2(`agg_max_words+1)-1:0]    size_t;
    // Valid input words in one output beat, 1 to agg_num_cols
    typedef logic [$clog2(`agg_num_cols+1)-1:0]     words_t;

    typedef struct packed {
        logic     valid;
        in_word_t data;
        logic     last;
    } in_beat_t;

    typedef struct packed {
        logic      valid;
        out_word_t data;
        logic      last;
        ctxt_t     ctxt;
        words_t    words;
    } out_beat_t;

    // Write offer of one input for its column in the current slot
    typedef struct packed {
        logic     req;
        row_t     row;
        in_word_t data;
    } col_wr_t;

    // Single-cycle page completion pulse
    typedef struct packed {
        logic  valid;
        size_t size;
    } desc_t;

    typedef enum logic {
        deq_idle,
        deq_read
    } deq_state_t;

endpackage : agg_pkg

//--- include/agg_defines.svh
// Width, count and depth macros for the packet aggregator
`ifndef agg_defines_svh
`define agg_defines_svh

// Number of narrow packet inputs
`define agg_num_inputs 4

// Input word width in bits
`define agg_in_width 16

// Memory columns, one input word wide each
`define agg_num_cols 4

// Output beat width, a full row across all columns
`define agg_out_width 64

// Rows in the page of one input
`define agg_page_rows 8

// Largest packet in input words, one full page
`define agg_max_words 32

// Write queue entries per input, twice the column count
`define agg_wq_depth 8

`endif
